// File: dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

   logic           clk;
   logic           rst_n;
   logic           mem_enable;
   logic           mem_rw;
   cpu_pkg::addr_t mem_addr;
   cpu_pkg::word_t mem_data_in;
   logic           mem_ack = 1'b0;
   cpu_pkg::word_t mem_data_out = '0;
   logic           halted;

   cpu_pkg::word_t init_image [65536];   // Memory contents at reset
   cpu_pkg::word_t mem [65536];
   cpu_pkg::word_t ref_mem [65536];      // Interpreter's view of memory
   cpu_pkg::addr_t exp_addr [$];
   cpu_pkg::word_t exp_data [$];
   cpu_pkg::addr_t want_addr;
   cpu_pkg::word_t want_data;

   integer seed;
   int     load_addr;
   int     delay_left;
   logic   waiting;
   bit     ref_halted;
   int     n_instr, cycle_limit, cycles;
   int     store_mismatches, store_errors, mem_mismatches, other_errors;

   cpu i_dut (
      .clk, .rst_n, .mem_enable, .mem_rw, .mem_addr, .mem_data_in,
      .mem_ack, .mem_data_out, .halted);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic cpu_pkg::word_t encode(input cpu_pkg::opcode_t op, input int rd,
                                             input int rs1, input int rs2, input int imm);
      return {op, 1'b0, rd[2:0], 1'b0, rs1[2:0], 1'b0, rs2[2:0], imm[15:0]};
   endfunction

   task automatic emit(input cpu_pkg::opcode_t op, input int rd, input int rs1,
                       input int rs2, input int imm);
      init_image[load_addr[15:0]] = encode(op, rd, rs1, rs2, imm);
      load_addr++;
   endtask

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Hand-written program starting at address 0
   task automatic load_fixed_program();
      load_addr = 0;
      emit(cpu_pkg::op_addi, 1, 0, 0, 5);
      emit(cpu_pkg::op_addi, 2, 0, 0, -3);
      emit(cpu_pkg::op_add,  3, 1, 2, 0);
      emit(cpu_pkg::op_sub,  4, 1, 2, 0);
      emit(cpu_pkg::op_and,  5, 3, 4, 0);
      emit(cpu_pkg::op_or,   6, 4, 2, 0);
      emit(cpu_pkg::op_addi, 0, 1, 0, 7);         // r0 must stay zero
      emit(cpu_pkg::op_add,  7, 0, 5, 0);
      emit(cpu_pkg::op_sw,   0, 0, 3, 'h100);
      emit(cpu_pkg::op_sw,   0, 0, 6, 'h101);
      emit(cpu_pkg::op_sw,   0, 0, 7, 'h102);
      emit(cpu_pkg::op_mul,  2, 1, 6, 0);
      emit(cpu_pkg::op_add,  3, 2, 1, 0);         // Uses the product right away
      emit(cpu_pkg::op_sw,   0, 0, 3, 'h103);
      emit(cpu_pkg::op_addi, 4, 0, 0, 'h1234);
      emit(cpu_pkg::op_mul,  1, 4, 4, 0);         // Independent products back to back
      emit(cpu_pkg::op_mul,  5, 4, 2, 0);
      emit(cpu_pkg::op_mul,  6, 2, 2, 0);
      emit(cpu_pkg::op_sw,   0, 0, 1, 'h104);
      emit(cpu_pkg::op_sw,   0, 0, 5, 'h105);
      emit(cpu_pkg::op_sw,   0, 0, 6, 'h106);
      emit(cpu_pkg::op_lw,   7, 0, 0, 'h104);     // Reads back an earlier store
      emit(cpu_pkg::op_add,  7, 7, 4, 0);
      emit(cpu_pkg::op_sw,   0, 0, 7, 'h107);
      emit(cpu_pkg::op_lw,   3, 0, 0, 'h10F);
      emit(cpu_pkg::op_beq,  0, 3, 3, 28);        // Taken
      emit(cpu_pkg::op_sw,   0, 0, 3, 'h108);
      emit(cpu_pkg::op_jmp,  0, 0, 0, 0);
      emit(cpu_pkg::op_beq,  0, 3, 7, 31);        // Not taken
      emit(cpu_pkg::op_sw,   0, 0, 3, 'h109);
      emit(cpu_pkg::op_jmp,  0, 0, 0, 34);        // Skips fill words at 32..33
      emit(cpu_pkg::op_sw,   0, 0, 4, 'h10A);
   endtask

   // Random code on r0..r4 so most instructions depend on a recent one
   task automatic load_random_program(input int base, input int len);
      int kind, halt_at, tgt;
      load_addr = base;
      halt_at   = base + len;
      for (int n = 0; n < len; n++) begin
         kind = rand_below(10);
         case (kind)
            0, 1, 2, 3: emit(cpu_pkg::opcode_t'(kind[3:0]), rand_below(5), rand_below(5),
                             rand_below(5), 0);
            4: emit(cpu_pkg::op_addi, rand_below(5), rand_below(5), 0, $random(seed));
            5, 9: emit(cpu_pkg::op_mul, rand_below(5), rand_below(5), rand_below(5), 0);
            6: emit(cpu_pkg::op_lw, rand_below(5), 0, 0, 'h100 + rand_below(16));
            7: emit(cpu_pkg::op_sw, 0, 0, rand_below(5), 'h100 + rand_below(16));
            default: begin
               tgt = load_addr + 2 + rand_below(3);   // Forward only
               if (tgt > halt_at) tgt = halt_at;
               emit(cpu_pkg::op_beq, 0, rand_below(5), rand_below(5), tgt);
            end
         endcase
      end
      emit(cpu_pkg::op_halt, 0, 0, 0, 0);
   endtask

   // ISA interpreter over ref_mem that records every store in order
   function automatic int run_reference();
      cpu_pkg::word_t r [8];
      cpu_pkg::word_t iw, a, b, imm, res;
      cpu_pkg::addr_t pc, ea;
      logic [2:0] rd;
      logic wr;
      int steps;
      bit stop;
      for (int i = 0; i < 8; i++) r[i] = '0;
      pc    = '0;
      steps = 0;
      stop  = 1'b0;
      while (!stop && steps < 10000) begin
         iw  = ref_mem[pc];
         rd  = iw[26:24];
         a   = r[iw[22:20]];
         b   = r[iw[18:16]];
         imm = {{16{iw[15]}}, iw[15:0]};
         ea  = cpu_pkg::addr_t'(a + imm);
         wr  = 1'b0;
         res = '0;
         pc  = pc + 16'd1;
         steps++;
         case (cpu_pkg::opcode_t'(iw[31:28]))
            cpu_pkg::op_add:  {wr, res} = {1'b1, a + b};
            cpu_pkg::op_sub:  {wr, res} = {1'b1, a - b};
            cpu_pkg::op_and:  {wr, res} = {1'b1, a & b};
            cpu_pkg::op_or:   {wr, res} = {1'b1, a | b};
            cpu_pkg::op_addi: {wr, res} = {1'b1, a + imm};
            cpu_pkg::op_mul:  {wr, res} = {1'b1, a * b};   // Low 32 bits
            cpu_pkg::op_lw:   {wr, res} = {1'b1, ref_mem[ea]};
            cpu_pkg::op_sw: begin
               ref_mem[ea] = b;
               exp_addr.push_back(ea);
               exp_data.push_back(b);
            end
            cpu_pkg::op_beq:  if (a == b) pc = iw[15:0];
            cpu_pkg::op_jmp:  pc = iw[15:0];
            cpu_pkg::op_halt: begin
               stop       = 1'b1;
               ref_halted = 1'b1;
            end
            default: stop = 1'b1;   // Undefined opcode
         endcase
         if (wr && rd != 3'd0) r[rd] = res;
      end
      return steps;
   endfunction

   // Memory model with 0 to 3 extra wait cycles per request
   always @(posedge clk) begin
      if (!rst_n) begin
         mem_ack <= 1'b0;
         waiting <= 1'b0;
         for (int i = 0; i < 65536; i++) mem[i[15:0]] <= init_image[i[15:0]];
      end else if (mem_ack) begin
         mem_ack <= 1'b0;
         waiting <= 1'b0;
         if (mem_rw) mem[mem_addr] <= mem_data_in;
      end else if (mem_enable && !waiting) begin
         waiting    <= 1'b1;
         delay_left <= rand_below(4);
      end else if (waiting) begin
         if (delay_left == 0) begin
            mem_ack      <= 1'b1;
            mem_data_out <= mem[mem_addr];
         end else begin
            delay_left <= delay_left - 1;
         end
      end
   end

   // Store checker in program order
   always @(posedge clk) begin
      if (rst_n && mem_enable && mem_ack && mem_rw) begin
         if (halted) begin
            store_errors++;
            $display("Memory write to %h at %0t after halted was raised", mem_addr, $time);
         end else if (exp_addr.size() == 0) begin
            store_errors++;
            $display("Extra store to %h at %0t that the program never makes", mem_addr, $time);
         end else begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            if (mem_addr !== want_addr || mem_data_in !== want_data) begin
               store_mismatches++;
               $display("Mismatch at %0t: store [%h] = %h, expected [%h] = %h",
                        $time, mem_addr, mem_data_in, want_addr, want_data);
            end
         end
      end
   end

   initial begin
      rst_n = 1'b0;
      seed  = 63735;
      for (int i = 0; i < 65536; i++) begin
         init_image[i[15:0]] = cpu_pkg::word_t'(i) * 32'h9E37_79B1 ^ {i[15:0], ~i[15:0]};
      end
      load_fixed_program();
      load_random_program(34, 60);
      ref_mem     = init_image;
      n_instr     = run_reference();
      cycle_limit = 20 * n_instr + 200;
      if (!ref_halted) begin
         other_errors++;
         $display("Reference interpreter did not reach HALT");
      end

      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      cycles = 0;
      while (!halted && cycles < cycle_limit) begin
         @(negedge clk);
         cycles++;
      end

      if (!halted) begin
         other_errors++;
         $display("Timeout: halted was never reached within %0d cycles", cycle_limit);
      end else begin
         repeat (30) @(negedge clk);   // Catch late writes
         if (exp_addr.size() != 0) begin
            other_errors++;
            $display("%0d expected stores never reached the memory port", exp_addr.size());
         end
         for (int i = 0; i < 65536; i++) begin
            if (mem[i[15:0]] !== ref_mem[i[15:0]]) begin
               mem_mismatches++;
               $display("Mismatch at %0t: final memory [%h] = %h, expected %h",
                        $time, i[15:0], mem[i[15:0]], ref_mem[i[15:0]]);
            end
         end
      end

      $display("Errors: store mismatches %0d, memory mismatches %0d, store errors %0d, other %0d",
               store_mismatches, mem_mismatches, store_errors, other_errors);
      if (store_mismatches + mem_mismatches + store_errors + other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: project.f
source/cpu_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/alu_stage.sv
source/mult_pipe.sv
source/mem_stage.sv
source/mem_arbiter.sv
source/cpu.sv
dv/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpu_tb -f project.f --Mdir obj_dir -o cpu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
   exit 0
fi
exit 1

// File: source/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              alu_issue,
   input  cpu_pkg::alu_op_t  alu_op,
   input  cpu_pkg::word_t    alu_a,
   input  cpu_pkg::word_t    alu_b,
   input  cpu_pkg::reg_idx_t alu_rd,
   output logic              we,
   output cpu_pkg::reg_idx_t wd_idx,
   output cpu_pkg::word_t    wd
);

   cpu_pkg::word_t result;

   always_comb begin
      case (alu_op)
         cpu_pkg::alu_sub: result = alu_a - alu_b;
         cpu_pkg::alu_and: result = alu_a & alu_b;
         cpu_pkg::alu_or:  result = alu_a | alu_b;
         default:          result = alu_a + alu_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) we <= 1'b0;
      else we <= alu_issue;   // Single-cycle write pulse
   end

   always_ff @(posedge clk) begin
      if (alu_issue) begin
         wd_idx <= alu_rd;
         wd     <= result;
      end
   end

endmodule

// File: source/cpu.sv
`timescale 1ns/1ps

module cpu (
   input  logic           clk,
   input  logic           rst_n,
   output logic           mem_enable,
   output logic           mem_rw,
   output cpu_pkg::addr_t mem_addr,
   output cpu_pkg::word_t mem_data_in,
   input  logic           mem_ack,
   input  cpu_pkg::word_t mem_data_out,
   output logic           halted
);

   // Fetch side
   logic              fetch_req, fetch_ack;
   cpu_pkg::addr_t    fetch_addr;
   cpu_pkg::word_t    fetch_rdata;
   logic              instr_valid, instr_take, redirect;
   cpu_pkg::word_t    instr;
   cpu_pkg::addr_t    instr_pc, redirect_pc;

   // Register file reads
   cpu_pkg::reg_idx_t rs1, rs2;
   cpu_pkg::word_t    rdata1, rdata2;

   // Issue buses
   logic              alu_issue, mul_issue, mem_issue, iss_mem_we;
   cpu_pkg::alu_op_t  alu_op;
   cpu_pkg::word_t    alu_a, alu_b, mul_a, mul_b, mem_wdata;
   cpu_pkg::reg_idx_t alu_rd, mul_rd, mem_rd;
   cpu_pkg::addr_t    mem_addr_i;

   // Data side
   logic              data_req, data_we, data_ack, mem_busy;
   cpu_pkg::addr_t    data_addr;
   cpu_pkg::word_t    data_wdata, data_rdata;

   // Write-back
   logic              alu_we, mul_we, ld_we, we_a;
   cpu_pkg::reg_idx_t alu_idx, mul_idx, ld_idx, wd_a_idx;
   cpu_pkg::word_t    alu_wd, mul_wd, ld_wd, wd_a;

   // Port A shared by ALU and loads, never in the same cycle
   assign we_a     = alu_we | ld_we;
   assign wd_a_idx = alu_we ? alu_idx : ld_idx;
   assign wd_a     = alu_we ? alu_wd : ld_wd;

   fetch_unit i_fetch (
      .clk, .rst_n, .fetch_req, .fetch_addr, .fetch_ack, .fetch_rdata,
      .instr_valid, .instr, .instr_pc, .instr_take, .redirect, .redirect_pc);

   register_file i_regs (
      .clk, .rs1, .rs2, .rdata1, .rdata2, .we_a, .wd_a_idx, .wd_a,
      .we_b(mul_we), .wd_b_idx(mul_idx), .wd_b(mul_wd));

   decode_stage i_decode (
      .clk, .rst_n, .instr_valid, .instr, .instr_pc, .instr_take,
      .redirect, .redirect_pc, .rs1, .rs2, .rdata1, .rdata2,
      .alu_issue, .alu_op, .alu_a, .alu_b, .alu_rd,
      .mul_issue, .mul_a, .mul_b, .mul_rd,
      .mem_issue, .mem_we(iss_mem_we), .mem_addr_i, .mem_wdata, .mem_rd,
      .we_a, .wd_a_idx, .we_b(mul_we), .wd_b_idx(mul_idx),
      .mem_busy, .halted);

   alu_stage i_alu (
      .clk, .rst_n, .alu_issue, .alu_op, .alu_a, .alu_b, .alu_rd,
      .we(alu_we), .wd_idx(alu_idx), .wd(alu_wd));

   mult_pipe i_mult (
      .clk, .rst_n, .mul_issue, .mul_a, .mul_b, .mul_rd,
      .we(mul_we), .wd_idx(mul_idx), .wd(mul_wd));

   mem_stage i_mem (
      .clk, .rst_n, .mem_issue, .mem_we(iss_mem_we), .mem_addr_i, .mem_wdata, .mem_rd,
      .data_req, .data_we, .data_addr, .data_wdata, .data_ack, .data_rdata,
      .mem_busy, .we(ld_we), .wd_idx(ld_idx), .wd(ld_wd));

   mem_arbiter i_arb (
      .clk, .rst_n, .fetch_req, .fetch_addr, .fetch_ack, .fetch_rdata,
      .data_req, .data_we, .data_addr, .data_wdata, .data_ack, .data_rdata,
      .mem_enable, .mem_rw, .mem_addr, .mem_data_in, .mem_ack, .mem_data_out);

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

   typedef logic [31:0] word_t;     // Data and instruction word
   typedef logic [15:0] addr_t;     // Word address
   typedef logic [2:0]  reg_idx_t;

   typedef enum logic [3:0] {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_and  = 4'd2,
      op_or   = 4'd3,
      op_addi = 4'd4,
      op_mul  = 4'd5,
      op_lw   = 4'd6,
      op_sw   = 4'd7,
      op_beq  = 4'd8,
      op_jmp  = 4'd9,
      op_halt = 4'd10
   } opcode_t;

   typedef enum logic [1:0] {
      alu_add = 2'd0,
      alu_sub = 2'd1,
      alu_and = 2'd2,
      alu_or  = 2'd3
   } alu_op_t;

   localparam int num_regs   = 8;
   localparam int mult_depth = 5;   // Multiply latency in cycles

   // Instruction fields
   localparam int op_msb  = 31;
   localparam int op_lsb  = 28;
   localparam int rd_msb  = 26;
   localparam int rd_lsb  = 24;
   localparam int rs1_msb = 22;
   localparam int rs1_lsb = 20;
   localparam int rs2_msb = 18;
   localparam int rs2_lsb = 16;
   localparam int imm_msb = 15;
   localparam int imm_lsb = 0;

endpackage

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              instr_valid,
   input  cpu_pkg::word_t    instr,
   input  cpu_pkg::addr_t    instr_pc,
   output logic              instr_take,
   output logic              redirect,
   output cpu_pkg::addr_t    redirect_pc,
   output cpu_pkg::reg_idx_t rs1,
   output cpu_pkg::reg_idx_t rs2,
   input  cpu_pkg::word_t    rdata1,
   input  cpu_pkg::word_t    rdata2,
   output logic              alu_issue,
   output cpu_pkg::alu_op_t  alu_op,
   output cpu_pkg::word_t    alu_a,
   output cpu_pkg::word_t    alu_b,
   output cpu_pkg::reg_idx_t alu_rd,
   output logic              mul_issue,
   output cpu_pkg::word_t    mul_a,
   output cpu_pkg::word_t    mul_b,
   output cpu_pkg::reg_idx_t mul_rd,
   output logic              mem_issue,
   output logic              mem_we,
   output cpu_pkg::addr_t    mem_addr_i,
   output cpu_pkg::word_t    mem_wdata,
   output cpu_pkg::reg_idx_t mem_rd,
   input  logic              we_a,
   input  cpu_pkg::reg_idx_t wd_a_idx,
   input  logic              we_b,
   input  cpu_pkg::reg_idx_t wd_b_idx,
   input  logic              mem_busy,
   output logic              halted
);

   cpu_pkg::opcode_t  op;
   cpu_pkg::reg_idx_t rd_idx;
   cpu_pkg::word_t    imm_sext;
   cpu_pkg::addr_t    target;
   logic use_rs1, use_rs2, writes_rd;
   logic hazard, go, halt_seen;
   logic [cpu_pkg::num_regs-1:0] busy, set_mask, clr_mask;

   assign op       = cpu_pkg::opcode_t'(instr[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
   assign rd_idx   = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
   assign rs1      = instr[cpu_pkg::rs1_msb:cpu_pkg::rs1_lsb];
   assign rs2      = instr[cpu_pkg::rs2_msb:cpu_pkg::rs2_lsb];
   assign target   = instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];   // Absolute branch target
   assign imm_sext = cpu_pkg::word_t'($signed(instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb]));

   // Operand usage per opcode
   always_comb begin
      use_rs1   = 1'b0;
      use_rs2   = 1'b0;
      writes_rd = 1'b0;
      case (op)
         cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
         cpu_pkg::op_mul: begin
            use_rs1   = 1'b1;
            use_rs2   = 1'b1;
            writes_rd = 1'b1;
         end
         cpu_pkg::op_addi, cpu_pkg::op_lw: begin
            use_rs1   = 1'b1;
            writes_rd = 1'b1;
         end
         cpu_pkg::op_sw, cpu_pkg::op_beq: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
         end
         default: ;   // JMP, HALT, unused codes
      endcase
   end

   assign hazard = (use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]) ||
                   (writes_rd && busy[rd_idx]);
   assign go         = instr_valid && !halt_seen && !mem_busy && !hazard;
   assign instr_take = go;

   // Branches resolve at issue
   assign redirect    = go && ((op == cpu_pkg::op_beq && rdata1 == rdata2) ||
                               op == cpu_pkg::op_jmp);
   assign redirect_pc = target;

   always_comb begin
      case (op)
         cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
         cpu_pkg::op_and: alu_op = cpu_pkg::alu_and;
         cpu_pkg::op_or:  alu_op = cpu_pkg::alu_or;
         default:         alu_op = cpu_pkg::alu_add;   // ADD and ADDI
      endcase
   end

   assign alu_issue = go && (op == cpu_pkg::op_add || op == cpu_pkg::op_sub ||
                             op == cpu_pkg::op_and || op == cpu_pkg::op_or ||
                             op == cpu_pkg::op_addi);
   assign alu_a     = rdata1;
   assign alu_b     = (op == cpu_pkg::op_addi) ? imm_sext : rdata2;
   assign alu_rd    = rd_idx;

   assign mul_issue = go && (op == cpu_pkg::op_mul);
   assign mul_a     = rdata1;
   assign mul_b     = rdata2;
   assign mul_rd    = rd_idx;

   assign mem_issue  = go && (op == cpu_pkg::op_lw || op == cpu_pkg::op_sw);
   assign mem_we     = (op == cpu_pkg::op_sw);
   assign mem_addr_i = cpu_pkg::addr_t'(rdata1 + imm_sext);   // Base plus offset
   assign mem_wdata  = rdata2;
   assign mem_rd     = rd_idx;

   // Scoreboard masks
   always_comb begin
      set_mask = '0;
      clr_mask = '0;
      if (go && writes_rd && rd_idx != '0) set_mask[rd_idx] = 1'b1;
      if (we_a) clr_mask[wd_a_idx] = 1'b1;
      if (we_b) clr_mask[wd_b_idx] = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy      <= '0;
         halt_seen <= 1'b0;
         halted    <= 1'b0;
      end else begin
         busy      <= (busy & ~clr_mask) | set_mask;
         halt_seen <= halt_seen | (go && op == cpu_pkg::op_halt);
         halted    <= halted | (halt_seen && busy == '0 && !mem_busy);   // Drained
      end
   end

   // Fetch holds its word unchanged until decode takes it
   a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid && !instr_take |=> instr_valid && $stable(instr) && $stable(instr_pc));

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
   input  logic             clk,
   input  logic             rst_n,
   output logic             fetch_req,
   output cpu_pkg::addr_t   fetch_addr,
   input  logic             fetch_ack,
   input  cpu_pkg::word_t   fetch_rdata,
   output logic             instr_valid,
   output cpu_pkg::word_t   instr,
   output cpu_pkg::addr_t   instr_pc,
   input  logic             instr_take,
   input  logic             redirect,
   input  cpu_pkg::addr_t   redirect_pc
);

   typedef enum logic [1:0] {idle, request, hold} state_t;

   state_t state;
   cpu_pkg::addr_t pc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
         pc    <= '0;
      end else begin
         case (state)
            idle: state <= request;
            request: if (fetch_ack) state <= hold;
            hold: begin
               if (instr_take) begin
                  state <= request;
                  pc    <= redirect ? redirect_pc : pc + 1'b1;   // Next fetch address
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // Fetch buffer, one word deep
   always_ff @(posedge clk) begin
      if (state == request && fetch_ack) instr <= fetch_rdata;
   end

   assign fetch_req   = (state == request);
   assign fetch_addr  = pc;
   assign instr_valid = (state == hold);
   assign instr_pc    = pc;

   // Request level must be held until the arbiter answers
   a_req_held : assert property (@(posedge clk) disable iff (!rst_n)
      fetch_req && !fetch_ack |=> fetch_req);

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           fetch_req,
   input  cpu_pkg::addr_t fetch_addr,
   output logic           fetch_ack,
   output cpu_pkg::word_t fetch_rdata,
   input  logic           data_req,
   input  logic           data_we,
   input  cpu_pkg::addr_t data_addr,
   input  cpu_pkg::word_t data_wdata,
   output logic           data_ack,
   output cpu_pkg::word_t data_rdata,
   output logic           mem_enable,
   output logic           mem_rw,
   output cpu_pkg::addr_t mem_addr,
   output cpu_pkg::word_t mem_data_in,
   input  logic           mem_ack,
   input  cpu_pkg::word_t mem_data_out
);

   typedef enum logic [1:0] {idle, fetch_owner, data_owner} state_t;

   state_t state;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
      end else begin
         case (state)
            idle: begin
               if (data_req) state <= data_owner;   // Data has priority
               else if (fetch_req) state <= fetch_owner;
            end
            fetch_owner, data_owner: if (mem_ack) state <= idle;
            default: state <= idle;
         endcase
      end
   end

   assign mem_enable  = (state != idle);
   assign mem_rw      = (state == data_owner) && data_we;
   assign mem_addr    = (state == data_owner) ? data_addr : fetch_addr;
   assign mem_data_in = data_wdata;

   // Ack goes straight back to the owner
   assign fetch_ack   = (state == fetch_owner) && mem_ack;
   assign data_ack    = (state == data_owner) && mem_ack;
   assign fetch_rdata = mem_data_out;
   assign data_rdata  = mem_data_out;

   a_enable_until_ack : assert property (@(posedge clk) disable iff (!rst_n)
      $fell(mem_enable) |-> $past(mem_ack));

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              mem_issue,
   input  logic              mem_we,
   input  cpu_pkg::addr_t    mem_addr_i,
   input  cpu_pkg::word_t    mem_wdata,
   input  cpu_pkg::reg_idx_t mem_rd,
   output logic              data_req,
   output logic              data_we,
   output cpu_pkg::addr_t    data_addr,
   output cpu_pkg::word_t    data_wdata,
   input  logic              data_ack,
   input  cpu_pkg::word_t    data_rdata,
   output logic              mem_busy,
   output logic              we,
   output cpu_pkg::reg_idx_t wd_idx,
   output cpu_pkg::word_t    wd
);

   logic done;

   assign done = data_req && data_ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         data_req <= 1'b0;
         mem_busy <= 1'b0;
         we       <= 1'b0;
      end else begin
         we <= done && !data_we;   // Load write-back the cycle after ack
         if (mem_issue) begin
            data_req <= 1'b1;
            mem_busy <= 1'b1;
         end else if (done) begin
            data_req <= 1'b0;
            mem_busy <= !data_we;   // Load stays busy through its write
         end else if (we) begin
            mem_busy <= 1'b0;
         end
      end
   end

   // Request latched at issue and held until ack
   always_ff @(posedge clk) begin
      if (mem_issue) begin
         data_we    <= mem_we;
         data_addr  <= mem_addr_i;
         data_wdata <= mem_wdata;
         wd_idx     <= mem_rd;
      end
      if (done) wd <= data_rdata;
   end

endmodule

// File: source/mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              mul_issue,
   input  cpu_pkg::word_t    mul_a,
   input  cpu_pkg::word_t    mul_b,
   input  cpu_pkg::reg_idx_t mul_rd,
   output logic              we,
   output cpu_pkg::reg_idx_t wd_idx,
   output cpu_pkg::word_t    wd
);

   localparam int last = cpu_pkg::mult_depth - 1;

   logic [cpu_pkg::mult_depth-1:0] vld;
   cpu_pkg::reg_idx_t tag [cpu_pkg::mult_depth];
   cpu_pkg::word_t    acc [cpu_pkg::mult_depth];
   cpu_pkg::word_t    a_q [cpu_pkg::mult_depth-2];   // Operands for byte stages 1..3
   cpu_pkg::word_t    b_q [cpu_pkg::mult_depth-2];

   always_ff @(posedge clk) begin
      if (!rst_n) vld <= '0;
      else vld <= {vld[last-1:0], mul_issue};
   end

   // Stage 0 forms the low byte product and stages 1..3 add one byte each
   always_ff @(posedge clk) begin
      a_q[0] <= mul_a;
      b_q[0] <= mul_b;
      acc[0] <= mul_a * mul_b[7:0];
      tag[0] <= mul_rd;
      for (int s = 1; s < last - 1; s++) begin
         a_q[s] <= a_q[s-1];
         b_q[s] <= b_q[s-1];
      end
      for (int s = 1; s < last; s++) begin
         acc[s] <= acc[s-1] + ((a_q[s-1] * b_q[s-1][8*s +: 8]) << (8*s));
      end
      for (int s = 1; s <= last; s++) begin
         tag[s] <= tag[s-1];
      end
      acc[last] <= acc[last-1];   // Output register
   end

   assign we     = vld[last];
   assign wd_idx = tag[last];
   assign wd     = acc[last];   // Low 32 bits of the product

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
   input  logic              clk,
   input  cpu_pkg::reg_idx_t rs1,
   input  cpu_pkg::reg_idx_t rs2,
   output cpu_pkg::word_t    rdata1,
   output cpu_pkg::word_t    rdata2,
   input  logic              we_a,
   input  cpu_pkg::reg_idx_t wd_a_idx,
   input  cpu_pkg::word_t    wd_a,
   input  logic              we_b,
   input  cpu_pkg::reg_idx_t wd_b_idx,
   input  cpu_pkg::word_t    wd_b
);

   cpu_pkg::word_t regs [cpu_pkg::num_regs];

   // Port A from ALU or load, port B from multiplier
   always_ff @(posedge clk) begin
      if (we_a && wd_a_idx != '0) regs[wd_a_idx] <= wd_a;
      if (we_b && wd_b_idx != '0) regs[wd_b_idx] <= wd_b;
   end

   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];   // r0 reads as zero
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

   // Scoreboard keeps the two write-back sources on different registers
   a_no_write_clash : assert property (@(posedge clk)
      we_a && we_b |-> (wd_a_idx != wd_b_idx) || (wd_a_idx == '0));

endmodule
